//--- source/icache_pkg.sv
package icache_pkg;

  //----------------------------------------
  // Cache geometry
  //----------------------------------------
  localparam int XLEN           = 32;                        // Word width
  localparam int LINE_WORDS     = 4;                         // Words per line, burst length
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int OFFS_BITS      = 4;                         // Byte offset in line
  localparam int WORD_OFFS_BITS = 2;                         // Word offset in line
  localparam int IDX_BITS       = 4;
  localparam int TAG_BITS       = XLEN - IDX_BITS - OFFS_BITS;
  localparam int LFSR_BITS      = 7;                         // Replacement LFSR width

  // Address slicing positions
  localparam int WOFFS_LSB = OFFS_BITS - WORD_OFFS_BITS;
  localparam int IDX_LSB   = OFFS_BITS;
  localparam int TAG_LSB   = OFFS_BITS + IDX_BITS;

  //----------------------------------------
  // Shared types
  //----------------------------------------
  typedef logic [XLEN-1:0]           addr_t;
  typedef logic [XLEN-1:0]           word_t;
  typedef logic [TAG_BITS-1:0]       tag_t;
  typedef logic [IDX_BITS-1:0]       idx_t;
  typedef logic [WORD_OFFS_BITS-1:0] woffs_t;
  typedef word_t [LINE_WORDS-1:0]    line_t;                 // Word 0 in the low bits
  typedef logic [WAYS-1:0]           way_sel_t;              // One-hot

endpackage

//--- source/icache_setup.sv
`timescale 1ns/1ps

module icache_setup
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_valid_i,
  input  addr_t  req_adr_i,
  output logic   req_ready_o,
  input  logic   stall_i,
  output logic   lk_valid_o,
  output tag_t   lk_tag_o,
  output idx_t   lk_idx_o,
  output woffs_t lk_woffs_o,
  output idx_t   rd_idx_o
);

  logic accept;

  assign req_ready_o = ~stall_i;
  assign accept      = req_valid_i & req_ready_o;

  // Memory read address straight from the incoming request
  assign rd_idx_o = req_adr_i[IDX_LSB +: IDX_BITS];

  //----------------------------------------
  // Lookup stage register
  //----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lk_valid_o <= 1'b0;
    end else if (!stall_i) begin
      lk_valid_o <= accept;  // Bubble when no request
    end
  end

  // Address fields, payload only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lk_tag_o   <= req_adr_i[TAG_LSB +: TAG_BITS];
      lk_idx_o   <= req_adr_i[IDX_LSB +: IDX_BITS];
      lk_woffs_o <= req_adr_i[WOFFS_LSB +: WORD_OFFS_BITS];
    end
  end

  // Fetches are whole words
  a_word_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (req_adr_i[WOFFS_LSB-1:0] == '0));

endmodule

//--- source/icache_memory.sv
`timescale 1ns/1ps

module icache_memory
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     stall_i,
  input  idx_t     rd_idx_i,
  input  logic     lk_valid_i,
  input  tag_t     lk_tag_i,
  output logic     hit_o,
  output line_t    hit_line_o,
  input  logic     fill_we_i,
  input  idx_t     fill_idx_i,
  input  tag_t     fill_tag_i,
  input  way_sel_t fill_way_i,
  input  line_t    fill_line_i,
  input  logic     flush_clr_i,
  input  idx_t     flush_idx_i
);

  //----------------------------------------
  // Storage
  //----------------------------------------
  tag_t             tag_mem  [WAYS][SETS];
  line_t            data_mem [WAYS][SETS];
  logic [SETS-1:0]  valid_q  [WAYS];         // Per way, one bit per set

  // Read registers, the lookup view
  tag_t             rd_tag   [WAYS];
  line_t            rd_line  [WAYS];
  logic [WAYS-1:0]  rd_vld;
  logic [WAYS-1:0]  match;

  logic             fwd;                     // Fill hits the set being read

  assign fwd = fill_we_i & (fill_idx_i == rd_idx_i);

  // Tag and data arrays, no reset
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we_i && fill_way_i[w]) begin
        tag_mem[w][fill_idx_i]  <= fill_tag_i;
        data_mem[w][fill_idx_i] <= fill_line_i;
      end
    end
  end

  // Valid bits, cleared by reset and by the flush sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (flush_clr_i) begin
          valid_q[w][flush_idx_i] <= 1'b0;
        end else if (fill_we_i && fill_way_i[w]) begin
          valid_q[w][fill_idx_i] <= 1'b1;
        end
      end
    end
  end

  //----------------------------------------
  // Synchronous read, held under stall
  //----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld <= '0;
    end else if (!stall_i) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fwd && fill_way_i[w]) rd_vld[w] <= 1'b1;  // Write-first
        else                      rd_vld[w] <= valid_q[w][rd_idx_i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fwd && fill_way_i[w]) begin
          rd_tag[w]  <= fill_tag_i;   // Line being written this edge
          rd_line[w] <= fill_line_i;
        end else begin
          rd_tag[w]  <= tag_mem[w][rd_idx_i];
          rd_line[w] <= data_mem[w][rd_idx_i];
        end
      end
    end
  end

  // Hit compare on both ways
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      match[w] = rd_vld[w] & (rd_tag[w] == lk_tag_i);
    end
  end

  assign hit_o      = lk_valid_i & (|match);
  assign hit_line_o = match[1] ? rd_line[1] : rd_line[0];

  // One way per fill, never during the flush sweep
  a_fill_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_we_i |-> ($onehot(fill_way_i) && !flush_clr_i));

endmodule

//--- source/icache_fill_ctrl.sv
`timescale 1ns/1ps

module icache_fill_ctrl
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     lk_valid_i,
  input  tag_t     lk_tag_i,
  input  idx_t     lk_idx_i,
  input  logic     hit_i,
  input  logic     resp_busy_i,
  output logic     stall_o,
  output logic     fill_we_o,
  output idx_t     fill_idx_o,
  output tag_t     fill_tag_o,
  output way_sel_t fill_way_o,
  output line_t    fill_line_o,
  output logic     fill_done_o,
  output logic     fill_err_o,
  output logic     flush_clr_o,
  output idx_t     flush_idx_o,
  output logic     flush_busy_o,
  output logic     bus_req_valid_o,
  input  logic     bus_req_ready_i,
  output addr_t    bus_adr_o,
  input  logic     bus_rvalid_i,
  input  word_t    bus_rdata_i,
  input  logic     bus_err_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_COLLECT,
    S_FLUSH
  } state_t;

  state_t               state_q;
  logic                 init_q;         // Low for the first cycle out of reset
  logic                 flush_pend_q;
  logic                 fill_done_q;
  logic                 err_q;
  woffs_t               beat_q;
  line_t                line_q;         // Burst beats collect here
  logic [LFSR_BITS-1:0] lfsr_q;

  logic miss;
  logic lk_taken;
  logic flush_start;
  logic last_beat;

  //----------------------------------------
  // Control decode
  //----------------------------------------
  assign lk_taken    = lk_valid_i & (hit_i | fill_done_q);   // Lookup served this cycle
  assign miss        = lk_valid_i & ~hit_i & ~fill_done_q & (state_q == S_IDLE);
  assign flush_start = flush_pend_q & ~lk_valid_i & ~fill_done_q & (state_q == S_IDLE);
  assign last_beat   = (state_q == S_COLLECT) & bus_rvalid_i &
                       (beat_q == WORD_OFFS_BITS'(LINE_WORDS - 1));

  assign stall_o = ~init_q | resp_busy_i | miss | (state_q != S_IDLE) |
                   (flush_pend_q & ~lk_taken);

  assign flush_busy_o = flush_pend_q | (state_q == S_FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) init_q <= 1'b0;
    else         init_q <= 1'b1;
  end

  // Flush waits here until no miss is running
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) flush_pend_q <= 1'b0;
    else         flush_pend_q <= flush_i | (flush_pend_q & ~flush_start);
  end

  //----------------------------------------
  // Miss and flush FSM
  //----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= S_IDLE;
      beat_q      <= '0;
      flush_idx_o <= '0;
      fill_done_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      fill_done_q <= last_beat | (fill_done_q & resp_busy_i);  // Held until taken
      case (state_q)
        S_IDLE: begin
          if (miss)             state_q <= S_REQ;
          else if (flush_start) state_q <= S_FLUSH;
        end
        S_REQ: begin
          if (bus_req_ready_i) begin
            state_q <= S_COLLECT;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        S_COLLECT: begin
          if (bus_rvalid_i) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= err_q | bus_err_i;   // Any bad beat spoils the line
            if (last_beat) state_q <= S_IDLE;
          end
        end
        S_FLUSH: begin
          flush_idx_o <= flush_idx_o + 1'b1;  // Wraps back to 0
          if (flush_idx_o == IDX_BITS'(SETS - 1)) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Missed address and line buffer, payload only
  always_ff @(posedge clk_i) begin
    if (miss) begin
      fill_tag_o <= lk_tag_i;
      fill_idx_o <= lk_idx_i;
    end
    if ((state_q == S_COLLECT) && bus_rvalid_i) begin
      line_q[beat_q] <= bus_rdata_i;
    end
  end

  //----------------------------------------
  // Random replacement
  //----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if ((state_q != S_REQ) && (state_q != S_COLLECT) && !fill_done_q) begin
      lfsr_q <= {lfsr_q[LFSR_BITS-2:0], lfsr_q[6] ~^ lfsr_q[5]};  // Frozen during a fill
    end
  end

  assign fill_way_o = lfsr_q[0] ? way_sel_t'(2'b10) : way_sel_t'(2'b01);

  assign bus_req_valid_o = (state_q == S_REQ);
  assign bus_adr_o       = {fill_tag_o, fill_idx_o, {OFFS_BITS{1'b0}}};  // Line aligned

  assign fill_line_o = line_q;
  assign fill_done_o = fill_done_q;
  assign fill_err_o  = err_q;
  assign fill_we_o   = fill_done_q & ~err_q & ~resp_busy_i;
  assign flush_clr_o = (state_q == S_FLUSH);

  a_no_beat_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == S_IDLE) |-> !bus_rvalid_i);

endmodule

//--- source/icache_resp.sv
`timescale 1ns/1ps

module icache_resp
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   hit_i,
  input  logic   lk_valid_i,
  input  woffs_t lk_woffs_i,
  input  line_t  hit_line_i,
  input  logic   fill_done_i,
  input  logic   fill_err_i,
  input  line_t  fill_line_i,
  output logic   rsp_valid_o,
  output word_t  rsp_data_o,
  output logic   rsp_err_o,
  input  logic   rsp_ready_i,
  output logic   resp_busy_o
);

  logic  load;
  word_t word;

  // Fill result has priority, lookup shows a miss then anyway
  assign load = fill_done_i | (lk_valid_i & hit_i);
  assign word = fill_done_i ? fill_line_i[lk_woffs_i] : hit_line_i[lk_woffs_i];

  // Held response not yet taken
  assign resp_busy_o = rsp_valid_o & ~rsp_ready_i;

  //----------------------------------------
  // Response register
  //----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else if (!resp_busy_o) begin
      rsp_valid_o <= load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!resp_busy_o && load) begin
      rsp_data_o <= word;
      rsp_err_o  <= fill_done_i & fill_err_i;  // Only a bus fill can fail
    end
  end

endmodule

//--- source/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  // Fetch port
  input  logic  req_valid_i,
  input  addr_t req_adr_i,
  output logic  req_ready_o,
  // Response port
  output logic  rsp_valid_o,
  output word_t rsp_data_o,
  output logic  rsp_err_o,
  input  logic  rsp_ready_i,
  // Bus port
  output logic  bus_req_valid_o,
  input  logic  bus_req_ready_i,
  output addr_t bus_adr_o,
  input  logic  bus_rvalid_i,
  input  word_t bus_rdata_i,
  input  logic  bus_err_i
);

  logic     stall, hit, resp_busy;
  logic     lk_valid;
  tag_t     lk_tag;
  idx_t     lk_idx, rd_idx;
  woffs_t   lk_woffs;
  line_t    hit_line, fill_line;
  logic     fill_we, fill_done, fill_err, flush_clr;
  idx_t     fill_idx, flush_idx;
  tag_t     fill_tag;
  way_sel_t fill_way;

  icache_setup i_setup (
    .clk_i, .rst_ni, .req_valid_i, .req_adr_i, .req_ready_o,
    .stall_i    (stall),
    .lk_valid_o (lk_valid),
    .lk_tag_o   (lk_tag),
    .lk_idx_o   (lk_idx),
    .lk_woffs_o (lk_woffs),
    .rd_idx_o   (rd_idx)
  );

  icache_memory i_memory (
    .clk_i, .rst_ni,
    .stall_i     (stall),
    .rd_idx_i    (rd_idx),
    .lk_valid_i  (lk_valid),
    .lk_tag_i    (lk_tag),
    .hit_o       (hit),
    .hit_line_o  (hit_line),
    .fill_we_i   (fill_we),
    .fill_idx_i  (fill_idx),
    .fill_tag_i  (fill_tag),
    .fill_way_i  (fill_way),
    .fill_line_i (fill_line),
    .flush_clr_i (flush_clr),
    .flush_idx_i (flush_idx)
  );

  icache_fill_ctrl i_fill_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .lk_valid_i   (lk_valid),
    .lk_tag_i     (lk_tag),
    .lk_idx_i     (lk_idx),
    .hit_i        (hit),
    .resp_busy_i  (resp_busy),
    .stall_o      (stall),
    .fill_we_o    (fill_we),
    .fill_idx_o   (fill_idx),
    .fill_tag_o   (fill_tag),
    .fill_way_o   (fill_way),
    .fill_line_o  (fill_line),
    .fill_done_o  (fill_done),
    .fill_err_o   (fill_err),
    .flush_clr_o  (flush_clr),
    .flush_idx_o  (flush_idx),
    .flush_busy_o (),
    .bus_req_valid_o, .bus_req_ready_i, .bus_adr_o,
    .bus_rvalid_i, .bus_rdata_i, .bus_err_i
  );

  icache_resp i_resp (
    .clk_i, .rst_ni,
    .hit_i       (hit),
    .lk_valid_i  (lk_valid),
    .lk_woffs_i  (lk_woffs),
    .hit_line_i  (hit_line),
    .fill_done_i (fill_done),
    .fill_err_i  (fill_err),
    .fill_line_i (fill_line),
    .rsp_valid_o, .rsp_data_o, .rsp_err_o, .rsp_ready_i,
    .resp_busy_o (resp_busy)
  );

endmodule

//--- verif/icache_bus_model.sv
`timescale 1ns/1ps

module icache_bus_model
  import icache_pkg::*;
#(
  parameter word_t DATA_KEY = 32'h0,   // XORed onto each word address
  parameter addr_t ERR_LO   = 32'h0,   // Error range, lower bound
  parameter addr_t ERR_HI   = 32'h0    // Error range, upper bound, exclusive
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  bus_req_valid_i,
  output logic  bus_req_ready_o,
  input  addr_t bus_adr_i,
  output logic  bus_rvalid_o,
  output word_t bus_rdata_o,
  output logic  bus_err_o
);

  logic   busy_q;   // Burst running
  addr_t  base_q;   // Line address of the burst
  woffs_t beat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_req_ready_o <= 1'b0;
      bus_rvalid_o    <= 1'b0;
      bus_rdata_o     <= '0;
      bus_err_o       <= 1'b0;
      busy_q          <= 1'b0;
      base_q          <= '0;
      beat_q          <= '0;
    end else begin
      bus_req_ready_o <= 1'b0;
      bus_rvalid_o    <= 1'b0;
      bus_err_o       <= 1'b0;
      if (bus_req_valid_i && bus_req_ready_o) begin
        busy_q <= 1'b1;          // Request taken, beats start next cycle
        base_q <= bus_adr_i;
        beat_q <= '0;
      end else if (bus_req_valid_i && !busy_q) begin
        bus_req_ready_o <= 1'b1;  // One wait cycle before accepting
      end
      if (busy_q) begin
        bus_rvalid_o <= 1'b1;
        bus_rdata_o  <= (base_q + addr_t'(beat_q) * 4) ^ DATA_KEY;
        bus_err_o    <= (base_q >= ERR_LO) && (base_q < ERR_HI);  // Whole line bad
        beat_q       <= beat_q + 1'b1;
        if (beat_q == woffs_t'(LINE_WORDS - 1)) busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam word_t DATA_KEY = 32'hA5C3_0F96;
  localparam addr_t ERR_LO   = 32'h0000_8000;
  localparam addr_t ERR_HI   = 32'h0000_8100;
  localparam int    TIMEOUT  = 300;            // Cycles per wait
  localparam int    NUM      = 20;

  typedef enum logic [1:0] {BUS_NO, BUS_YES, BUS_ANY} bus_exp_e;

  typedef struct packed {
    addr_t    adr;
    logic     flush;     // Pulse flush_i before the fetch
    bus_exp_e bus;
    logic     err;
  } entry_t;

  logic  clk_i = 1'b0;
  logic  rst_ni, flush_i;
  logic  req_valid_i, req_ready_o;
  addr_t req_adr_i;
  logic  rsp_valid_o, rsp_err_o, rsp_ready_i;
  word_t rsp_data_o;
  logic  bus_req_valid_o, bus_req_ready_i, bus_rvalid_i, bus_err_i;
  addr_t bus_adr_o;
  word_t bus_rdata_i;

  entry_t      stim [NUM];
  addr_t       stream_q [$];
  int          bus_count = 0;
  int          rsp_count = 0;
  int          bus_before;
  logic        adr_chk_en = 1'b0;
  addr_t       exp_line = '0;

  icache_top i_dut (.*);

  icache_bus_model #(.DATA_KEY(DATA_KEY), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) i_mem (
    .clk_i, .rst_ni,
    .bus_req_valid_i (bus_req_valid_o),
    .bus_req_ready_o (bus_req_ready_i),
    .bus_adr_i       (bus_adr_o),
    .bus_rvalid_o    (bus_rvalid_i),
    .bus_rdata_o     (bus_rdata_i),
    .bus_err_o       (bus_err_i)
  );

  always #20 clk_i = ~clk_i;

  // Random response back-pressure, ready about three cycles in four
  initial begin
    void'($urandom(4786));
    forever begin
      @(posedge clk_i);
      rsp_ready_i <= ($urandom % 4) != 0;
    end
  end

  //----------------------------------------
  // Checks and helpers
  //----------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                               $time, name, got, exp));
  endtask

  // Word address XOR key, as the memory holds it
  function automatic word_t model_word(input addr_t adr);
    return {adr[XLEN-1:2], 2'b00} ^ DATA_KEY;
  endfunction

  // Starts right after a rising edge, returns on the transfer edge
  task automatic send_req(input addr_t adr);
    int n;
    n = 0;
    req_valid_i <= 1'b1;
    req_adr_i   <= adr;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_failure($sformatf("Request %h was never accepted", adr));
    end while (!req_ready_o);
    @(posedge clk_i);
  endtask

  // Returns at the falling edge before the response handshake
  task automatic wait_rsp();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_failure("No response came back from the cache");
    end while (!(rsp_valid_o && rsp_ready_i));
  endtask

  // Bus and response monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (bus_req_valid_o && bus_req_ready_i) begin
      bus_count++;
      if (adr_chk_en) check_addr("bus_adr_o", bus_adr_o, exp_line);
    end
    if (rsp_valid_o && rsp_ready_i) rsp_count++;
  end

  //----------------------------------------
  // Stimulus
  //----------------------------------------
  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_adr_i   = '0;
    rsp_ready_i = 1'b1;

    stim[0]  = '{32'h0000_1004, 1'b0, BUS_YES, 1'b0};  // First fetch of a line
    stim[1]  = '{32'h0000_1000, 1'b0, BUS_NO,  1'b0};
    stim[2]  = '{32'h0000_100C, 1'b0, BUS_NO,  1'b0};
    stim[3]  = '{32'h0000_1008, 1'b0, BUS_NO,  1'b0};
    stim[4]  = '{32'h0000_1010, 1'b0, BUS_YES, 1'b0};
    stim[5]  = '{32'h0000_1014, 1'b0, BUS_NO,  1'b0};
    stim[6]  = '{32'h0000_2020, 1'b0, BUS_YES, 1'b0};  // Three lines on set 2
    stim[7]  = '{32'h0000_3024, 1'b0, BUS_YES, 1'b0};
    stim[8]  = '{32'h0000_402C, 1'b0, BUS_YES, 1'b0};
    stim[9]  = '{32'h0000_2028, 1'b0, BUS_ANY, 1'b0};
    stim[10] = '{32'h0000_3020, 1'b0, BUS_ANY, 1'b0};
    stim[11] = '{32'h0000_4024, 1'b0, BUS_ANY, 1'b0};
    stim[12] = '{32'h0000_2020, 1'b0, BUS_ANY, 1'b0};
    stim[13] = '{32'h0000_3028, 1'b0, BUS_ANY, 1'b0};
    stim[14] = '{32'h0000_8044, 1'b0, BUS_YES, 1'b1};  // Error range
    stim[15] = '{32'h0000_8044, 1'b0, BUS_YES, 1'b1};  // Line never written
    stim[16] = '{32'h0000_1000, 1'b0, BUS_NO,  1'b0};
    stim[17] = '{32'h0000_1004, 1'b1, BUS_YES, 1'b0};  // Flush first
    stim[18] = '{32'h0000_1014, 1'b0, BUS_YES, 1'b0};
    stim[19] = '{32'h0000_1018, 1'b0, BUS_NO,  1'b0};

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // One entry at a time
    adr_chk_en = 1'b1;
    for (int i = 0; i < NUM; i++) begin
      @(posedge clk_i);
      check_word("response count", word_t'(rsp_count), word_t'(i));
      if (stim[i].flush) begin
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
      end
      exp_line   = {stim[i].adr[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}};
      bus_before = bus_count;
      send_req(stim[i].adr);
      req_valid_i <= 1'b0;
      wait_rsp();
      check_bit("rsp_err_o", rsp_err_o, stim[i].err);
      if (!stim[i].err) check_word("rsp_data_o", rsp_data_o, model_word(stim[i].adr));
      if (stim[i].bus != BUS_ANY)
        check_word("bus request count", word_t'(bus_count - bus_before),
                   (stim[i].bus == BUS_YES) ? 32'd1 : 32'd0);
    end

    //----------------------------------------
    // Back-to-back stream, order check
    //----------------------------------------
    adr_chk_en = 1'b0;
    foreach (stim[k]) begin
      if (!stim[k].flush && !stim[k].err) stream_q.push_back(stim[k].adr);
    end
    @(posedge clk_i);
    fork
      begin
        foreach (stream_q[k]) send_req(stream_q[k]);
        req_valid_i <= 1'b0;
      end
      begin
        foreach (stream_q[k]) begin
          wait_rsp();
          check_bit("rsp_err_o", rsp_err_o, 1'b0);
          check_word("rsp_data_o", rsp_data_o, model_word(stream_q[k]));
        end
      end
    join

    // Nothing extra may trail the stream
    repeat (8) @(posedge clk_i);
    check_word("response count", word_t'(rsp_count), word_t'(NUM + stream_q.size()));
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- build.f
source/icache_pkg.sv
source/icache_setup.sv
source/icache_memory.sv
source/icache_fill_ctrl.sv
source/icache_resp.sv
source/icache_top.sv
verif/icache_bus_model.sv
verif/icache_tb.sv
